/* bench/ps2_key_display_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_key_display_assert (
    input wire logic                                            clk,
    input wire logic                                            rst,
    input wire logic                                            byte_ack,
    input wire logic                                            byte_ready,
    input wire logic [ps2_pkg::NUM_DIGITS*ps2_pkg::SEG_WIDTH-1:0] segs
);

    // blank or one of the sixteen hex patterns
    function automatic logic legal_segment(input logic [7:0] seg);
        case (seg)
            8'h00, 8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
            8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71: legal_segment = 1'b1;
            default: legal_segment = 1'b0;
        endcase
    endfunction

    a_ack_needs_ready: assert property (@(posedge clk) disable iff (!rst)
        byte_ack |-> byte_ready)
        else $error("byte_ack raised while byte_ready is low");

    a_ready_low_after_reset: assert property (@(posedge clk)
        $rose(rst) |-> !byte_ready)
        else $error("byte_ready high right after reset release");

    genvar i;
    generate
        for (i = 0; i < ps2_pkg::NUM_DIGITS; i++)
        begin : g_seg_check
            a_legal_digit: assert property (@(posedge clk) disable iff (!rst)
                legal_segment(segs[i*ps2_pkg::SEG_WIDTH +: ps2_pkg::SEG_WIDTH]))
                else $error("digit %0d shows an illegal segment byte", i);
        end
    endgenerate

endmodule

bind ps2_key_display ps2_key_display_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .byte_ack   (byte_ack),
    .byte_ready (byte_ready),
    .segs       (segs)
);

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        rst = 1'b0;
    end

    always #5 clk = ~clk; // 10 ns period

    // active low reset held for two rising edges
    initial
    begin
        repeat (2) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

`default_nettype wire

/* bench/tb_ps2_key_display.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_key_display;

    localparam int NUM_ROWS  = 8;
    localparam int SEGS_W    = ps2_pkg::NUM_DIGITS * ps2_pkg::SEG_WIDTH;
    localparam int LIMIT     = NUM_ROWS * 4 * 300 + 2000;

    logic              clk;
    logic              rst;
    logic              ps2_clk;
    logic              ps2_dat;
    logic [SEGS_W-1:0] segs;

    string       row_name   [NUM_ROWS];
    int          row_count  [NUM_ROWS];
    logic [7:0]  row_bytes  [NUM_ROWS][4];
    logic [3:0]  row_bad    [NUM_ROWS];
    logic        row_trunc  [NUM_ROWS];
    logic [7:0]  exp_code   [NUM_ROWS];
    logic [7:0]  exp_count  [NUM_ROWS];
    logic        exp_blank  [NUM_ROWS];

    int          pass_count;
    int          fail_count;
    int          cycle_count;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    ps2_key_display #(
        .FRAME_TIMEOUT (400)
    ) u_ps2_key_display (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .segs    (segs)
    );

    // gfedcba, active high
    function automatic logic [7:0] hex_to_segments(input logic [3:0] nibble);
        logic [7:0] table_seg [16];
        begin
            table_seg = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                          8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};
            hex_to_segments = table_seg[nibble];
        end
    endfunction

    function automatic logic [SEGS_W-1:0] expected_segs(input logic [7:0] code,
                                                        input logic [7:0] count,
                                                        input logic blank);
        logic [15:0]       nibbles;
        logic [SEGS_W-1:0] result;
        int                d;
        begin
            nibbles = {count, code};
            result  = '0;
            for (d = 0; d < ps2_pkg::NUM_DIGITS; d++)
            begin
                if (!blank)
                begin
                    result[d*8 +: 8] = hex_to_segments(nibbles[d*4 +: 4]);
                end
            end
            expected_segs = result;
        end
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // start, data LSB first, odd parity, stop; nbits below 11 cuts the frame short
    task automatic send_frame(input logic [7:0] data, input logic bad_parity, input int nbits);
        logic [10:0] bits;
        logic        parity;
        int          i;
        begin
            parity = ~^data;
            if (bad_parity)
            begin
                parity = ~parity;
            end
            bits = {1'b1, parity, data, 1'b0};
            for (i = 0; i < nbits; i++)
            begin
                wait_cycles(5);
                ps2_dat <= bits[i];
                wait_cycles(5);
                ps2_clk <= 1'b0;
                wait_cycles(10);
                ps2_clk <= 1'b1;
            end
            wait_cycles(1);
            ps2_dat <= 1'b1;
        end
    endtask

    task automatic load_row(input int r, input string name, input int n,
                            input logic [7:0] b0, input logic [7:0] b1,
                            input logic [7:0] b2, input logic [7:0] b3,
                            input logic [3:0] bad, input logic trunc,
                            input logic [7:0] code, input logic [7:0] count,
                            input logic blank);
        row_name[r]     = name;
        row_count[r]    = n;
        row_bytes[r][0] = b0;
        row_bytes[r][1] = b1;
        row_bytes[r][2] = b2;
        row_bytes[r][3] = b3;
        row_bad[r]      = bad;
        row_trunc[r]    = trunc;
        exp_code[r]     = code;
        exp_count[r]    = count;
        exp_blank[r]    = blank;
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= LIMIT)
        begin
            $display("ERROR: the run did not finish within %0d cycles", LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        logic [SEGS_W-1:0] expected;
        logic [SEGS_W-1:0] prev_expected;
        logic              row_ok;
        int                r;
        int                b;

        ps2_clk       = 1'b1;
        ps2_dat       = 1'b1;
        pass_count    = 0;
        fail_count    = 0;
        cycle_count   = 0;
        prev_expected = '0;

        load_row(0, "reset_state",     0, 8'h00, 8'h00, 8'h00, 8'h00, 4'b0000, 1'b0,
                 8'h00, 8'h00, 1'b1);
        load_row(1, "make_then_break", 3, 8'h1C, 8'hF0, 8'h1C, 8'h00, 4'b0000, 1'b0,
                 8'h1C, 8'h01, 1'b0);
        load_row(2, "make_only",       2, 8'h32, 8'hE0, 8'h00, 8'h00, 4'b0000, 1'b0,
                 8'h1C, 8'h01, 1'b0);
        load_row(3, "bad_parity",      3, 8'hF0, 8'h23, 8'h23, 8'h00, 4'b0010, 1'b0,
                 8'h23, 8'h02, 1'b0);
        load_row(4, "truncated_frame", 2, 8'hF0, 8'h2B, 8'h00, 8'h00, 4'b0000, 1'b1,
                 8'h2B, 8'h03, 1'b0);
        load_row(5, "count_step_a",    2, 8'hF0, 8'h5A, 8'h00, 8'h00, 4'b0000, 1'b0,
                 8'h5A, 8'h04, 1'b0);
        load_row(6, "count_step_b",    4, 8'hF0, 8'h76, 8'hF0, 8'h4E, 4'b0000, 1'b0,
                 8'h4E, 8'h06, 1'b0);
        load_row(7, "count_step_c",    3, 8'h4D, 8'hF0, 8'h4D, 8'h00, 4'b0000, 1'b0,
                 8'h4D, 8'h07, 1'b0);

        @(posedge clk);
        while (!rst)
        begin
            @(posedge clk);
        end

        for (r = 0; r < NUM_ROWS; r++)
        begin
            row_ok = 1'b1;
            if (row_trunc[r])
            begin
                send_frame(8'h55, 1'b0, 5); // start bit and four data bits, then silence
                wait_cycles(600);
            end
            for (b = 0; b < row_count[r]; b++)
            begin
                send_frame(row_bytes[r][b], row_bad[r][b], 11);
                wait_cycles(60);
                if (row_bad[r][b])
                begin
                    // a dropped frame leaves the display as the previous row left it
                    @(negedge clk);
                    if (segs !== prev_expected)
                    begin
                        $display("CHECK FAILED %s dropped frame expected %h actual %h",
                                 row_name[r], prev_expected, segs);
                        row_ok = 1'b0;
                    end
                end
            end
            wait_cycles(40);
            @(negedge clk);
            expected = expected_segs(exp_code[r], exp_count[r], exp_blank[r]);
            if (segs !== expected)
            begin
                $display("CHECK FAILED %s expected %h actual %h", row_name[r], expected, segs);
                row_ok = 1'b0;
            end
            if (row_ok)
            begin
                $display("pass %s segs %h", row_name[r], segs);
                pass_count++;
            end
            else
            begin
                fail_count++;
            end
            prev_expected = expected;
        end

        $display("rows passed %0d, rows failed %0d", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    // tracker states, the break path takes two extra steps before the update
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_TAKE       = 3'd1,
        ST_BREAK_WAIT = 3'd2,
        ST_BREAK_TAKE = 3'd3,
        ST_UPDATE     = 3'd4
    } key_state_e;

    // a PS/2 frame is start, 8 data bits LSB first, odd parity and stop
    localparam int FRAME_BITS = 11;

    // the prefix the keyboard sends ahead of a released key
    localparam logic [7:0] BREAK_CODE = 8'hF0;

    // one digit is gfedcba in bits 6..0 with the decimal point in bit 7
    localparam int SEG_WIDTH = 8;

    localparam logic [SEG_WIDTH-1:0] SEG_BLANK = 8'h00;

    // two bytes are shown, each as a pair of hex digits
    localparam int NUM_DIGITS = 4;

endpackage

`default_nettype wire

/* hw/hex_seg_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module hex_seg_decoder (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [3:0]                    nibble,
    input  wire logic                          blank,
    output logic [ps2_pkg::SEG_WIDTH-1:0]      seg
);

    logic [ps2_pkg::SEG_WIDTH-1:0] pattern;

    // active high gfedcba, decimal point never lit
    always_comb
    begin
        case (nibble)
            4'h0:    pattern = 8'h3F;
            4'h1:    pattern = 8'h06;
            4'h2:    pattern = 8'h5B;
            4'h3:    pattern = 8'h4F;
            4'h4:    pattern = 8'h66;
            4'h5:    pattern = 8'h6D;
            4'h6:    pattern = 8'h7D;
            4'h7:    pattern = 8'h07;
            4'h8:    pattern = 8'h7F;
            4'h9:    pattern = 8'h6F;
            4'hA:    pattern = 8'h77;
            4'hB:    pattern = 8'h7C; // lower case b so it differs from 8
            4'hC:    pattern = 8'h39;
            4'hD:    pattern = 8'h5E; // lower case d so it differs from 0
            4'hE:    pattern = 8'h79;
            default: pattern = 8'h71;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst || blank)
        begin
            seg <= ps2_pkg::SEG_BLANK;
        end
        else
        begin
            seg <= pattern;
        end
    end

endmodule

`default_nettype wire

/* hw/key_release_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module key_release_tracker (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [7:0] rx_byte,
    input  wire logic       byte_ready,
    output logic            byte_ack,
    output logic [7:0]      show_code,
    output logic [7:0]      release_count,
    output logic            blank
);

    ps2_pkg::key_state_e state;
    ps2_pkg::key_state_e next_state;
    logic [7:0]          key_byte;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state <= ps2_pkg::ST_IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ps2_pkg::ST_IDLE:
            begin
                if (byte_ready)
                begin
                    next_state = ps2_pkg::ST_TAKE;
                end
            end
            ps2_pkg::ST_TAKE:
            begin
                // make codes and the E0 prefix are simply dropped here
                if (rx_byte == ps2_pkg::BREAK_CODE)
                begin
                    next_state = ps2_pkg::ST_BREAK_WAIT;
                end
                else
                begin
                    next_state = ps2_pkg::ST_IDLE;
                end
            end
            ps2_pkg::ST_BREAK_WAIT:
            begin
                if (byte_ready)
                begin
                    next_state = ps2_pkg::ST_BREAK_TAKE;
                end
            end
            ps2_pkg::ST_BREAK_TAKE: next_state = ps2_pkg::ST_UPDATE;
            ps2_pkg::ST_UPDATE:     next_state = ps2_pkg::ST_IDLE;
            default:                next_state = ps2_pkg::ST_IDLE;
        endcase
    end

    // the receiver keeps byte_ready up through both ack states
    assign byte_ack = (state == ps2_pkg::ST_TAKE) || (state == ps2_pkg::ST_BREAK_TAKE);

    always_ff @(posedge clk)
    begin
        if (state == ps2_pkg::ST_BREAK_TAKE)
        begin
            key_byte <= rx_byte; // held here since the receiver may refill after the ack
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ps2_pkg::ST_UPDATE)
        begin
            show_code <= key_byte;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            release_count <= 8'd0;
            blank         <= 1'b1;
        end
        else if (state == ps2_pkg::ST_UPDATE)
        begin
            release_count <= release_count + 8'd1; // wraps at 256
            blank         <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/ps2_key_display.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_key_display #(
    parameter int FRAME_TIMEOUT = 400
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  ps2_clk,
    input  wire logic  ps2_dat,
    output logic [ps2_pkg::NUM_DIGITS*ps2_pkg::SEG_WIDTH-1:0] segs
);

    logic [7:0]                       rx_byte;
    logic                             byte_ready;
    logic                             byte_ack;
    logic [7:0]                       show_code;
    logic [7:0]                       release_count;
    logic                             blank;
    logic [4*ps2_pkg::NUM_DIGITS-1:0] digit_nibbles;

    ps2_frame_rx #(
        .FRAME_TIMEOUT (FRAME_TIMEOUT)
    ) u_frame_rx (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .byte_ack   (byte_ack),
        .rx_byte    (rx_byte),
        .byte_ready (byte_ready)
    );

    key_release_tracker u_tracker (
        .clk           (clk),
        .rst           (rst),
        .rx_byte       (rx_byte),
        .byte_ready    (byte_ready),
        .byte_ack      (byte_ack),
        .show_code     (show_code),
        .release_count (release_count),
        .blank         (blank)
    );

    // digits 1..0 carry the key code and digits 3..2 the release count
    assign digit_nibbles = {release_count, show_code};

    genvar i;
    generate
        for (i = 0; i < ps2_pkg::NUM_DIGITS; i++)
        begin : g_digit
            hex_seg_decoder u_dec (
                .clk    (clk),
                .rst    (rst),
                .nibble (digit_nibbles[4*i +: 4]),
                .blank  (blank),
                .seg    (segs[i*ps2_pkg::SEG_WIDTH +: ps2_pkg::SEG_WIDTH])
            );
        end
    endgenerate

endmodule

`default_nettype wire

/* ps2_key_display.f */
common/ps2_pkg.sv
ps2_rx/ps2_frame_rx.sv
hw/key_release_tracker.sv
hw/hex_seg_decoder.sv
hw/ps2_key_display.sv
bench/tb_clock.sv
bench/ps2_key_display_assert.sv
bench/tb_ps2_key_display.sv

/* ps2_rx/ps2_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx #(
    parameter int FRAME_TIMEOUT = 400
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       ps2_clk,
    input  wire logic       ps2_dat,
    input  wire logic       byte_ack,
    output logic [7:0]      rx_byte,
    output logic            byte_ready
);

    localparam int IDLE_W = $clog2(FRAME_TIMEOUT + 1);

    logic [1:0]                        clk_sync;
    logic [1:0]                        dat_sync;
    logic                              clk_prev;
    logic                              fall;
    logic [3:0]                        bit_cnt;
    logic [ps2_pkg::FRAME_BITS-2:0]    shift;
    logic [IDLE_W-1:0]                 idle_cnt;
    logic                              idle_expired;
    logic                              last_bit;
    logic                              frame_ok;

    // both lines idle high, so the synchronizers come out of reset at one
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign fall         = clk_prev & ~clk_sync[1];
    assign last_bit     = (bit_cnt == 4'(ps2_pkg::FRAME_BITS - 1));
    assign idle_expired = (idle_cnt == IDLE_W'(FRAME_TIMEOUT));

    // shift[0] is the start bit, shift[8:1] the data and shift[9] the parity,
    // the stop bit is still on the synchronized line when the frame is judged
    assign frame_ok = fall & last_bit & ~shift[0] & dat_sync[1] & (^shift[9:1]);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt  <= 4'd0;
            idle_cnt <= '0;
        end
        else if (fall)
        begin
            idle_cnt <= '0;
            bit_cnt  <= last_bit ? 4'd0 : bit_cnt + 4'd1;
        end
        else if (bit_cnt != 4'd0)
        begin
            // a device that stops in mid frame leaves the counter stranded
            if (idle_expired)
            begin
                bit_cnt  <= 4'd0;
                idle_cnt <= '0;
            end
            else
            begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
        else
        begin
            idle_cnt <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall && !last_bit)
        begin
            shift <= {dat_sync[1], shift[ps2_pkg::FRAME_BITS-2:1]}; // LSB arrives first
        end
    end

    always_ff @(posedge clk)
    begin
        if (frame_ok)
        begin
            rx_byte <= shift[8:1];
        end
    end

    // a fresh frame wins over an ack in the same cycle so it is not lost
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            byte_ready <= 1'b0;
        end
        else if (frame_ok)
        begin
            byte_ready <= 1'b1;
        end
        else if (byte_ack)
        begin
            byte_ready <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ps2_key_display -f ps2_key_display.f -o sim_ps2_key_display \
    > build.log 2>&1 \
    && ./obj_dir/sim_ps2_key_display > sim.log 2>&1 \
    || echo "build or simulation stopped with an error"

grep -qx "Done: no errors" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
